/* rtl/tile_pkg.sv */
// shared types, bus beat layout and row address rule for the tile mover blocks
package tile_pkg;

    typedef logic [31:0] word_t; // one feature-map element
    typedef logic [31:0] addr_t; // byte address or byte length

    localparam int WORDS_PER_BEAT = 4;

    // word 0 in the low bits, lowest address
    typedef word_t [WORDS_PER_BEAT-1:0] beat_t;

    typedef logic [15:0] coord_t;

    typedef struct packed {
        coord_t m;
        coord_t row;
        coord_t col;
    } tile_origin_t;

    typedef struct packed {
        addr_t base;
        addr_t length; // bytes
    } mst_cmd_t;

    // byte address of tile row (map_i, row_j) inside a feature map at base
    function automatic addr_t row_addr(
        input addr_t        base,
        input tile_origin_t org,
        input coord_t       map_i,
        input coord_t       row_j,
        input int unsigned  fm_rows,
        input int unsigned  fm_cols
    );
        addr_t line;
        line = (addr_t'(org.m) + addr_t'(map_i)) * addr_t'(fm_rows)
             + addr_t'(org.row) + addr_t'(row_j);
        return base + ((line * addr_t'(fm_cols) + addr_t'(org.col)) << 2);
    endfunction

endpackage

/* rtl/tile_load_ctrl.sv */
// load side: issues one read job per tile row and unpacks beats into FIFO words
`timescale 1ns/1ps

module tile_load_ctrl #(
    parameter int FM_ROWS   = 4,
    parameter int FM_COLS   = 16,
    parameter int TILE_MAPS = 2,
    parameter int TILE_ROWS = 4,
    parameter int TILE_COLS = 8
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   load_start,
    input  tile_pkg::tile_origin_t origin,
    input  tile_pkg::addr_t        src_base,
    output logic                   rd_go,
    output tile_pkg::mst_cmd_t     rd_cmd,
    output logic                   rd_read_buffer,
    input  tile_pkg::beat_t        rd_buffer_data,
    input  logic                   rd_data_available,
    input  logic                   rd_done,
    output logic                   push,
    output tile_pkg::word_t        push_data,
    input  logic                   almost_full,
    output logic                   load_done
);

    localparam int TOTAL_BEATS = TILE_MAPS * TILE_ROWS * TILE_COLS / tile_pkg::WORDS_PER_BEAT;
    localparam int BC_W        = $clog2(TOTAL_BEATS + 1);

    typedef enum logic [1:0] {S_IDLE, S_ISSUE, S_WAIT, S_DRAIN} state_t;

    state_t            state;
    tile_pkg::coord_t  map_cnt;
    tile_pkg::coord_t  row_cnt;
    logic [BC_W-1:0]   beat_cnt;
    tile_pkg::beat_t   beat_q;
    logic              full_q;
    logic [1:0]        word_idx;
    logic              last_row;
    logic              last_word;
    logic              all_in;

    assign last_row  = (map_cnt == tile_pkg::coord_t'(TILE_MAPS - 1)) &&
                       (row_cnt == tile_pkg::coord_t'(TILE_ROWS - 1));
    assign last_word = push && (word_idx == 2'd3);
    assign all_in    = (beat_cnt == BC_W'(TOTAL_BEATS)) && !full_q;

    assign rd_go         = (state == S_ISSUE);
    assign rd_cmd.base   = tile_pkg::row_addr(src_base, origin, map_cnt, row_cnt,
                                              FM_ROWS, FM_COLS);
    assign rd_cmd.length = tile_pkg::addr_t'(TILE_COLS * 4);

    // next beat may land as the last word of the current one leaves
    assign rd_read_buffer = (state != S_IDLE) && rd_data_available && (!full_q || last_word);
    assign push           = full_q && !almost_full;
    assign push_data      = beat_q[word_idx];
    assign load_done      = (state == S_DRAIN) && all_in;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= S_IDLE;
            map_cnt <= '0;
            row_cnt <= '0;
        end else begin
            case (state)
                S_IDLE: if (load_start) begin
                    map_cnt <= '0;
                    row_cnt <= '0;
                    state   <= S_ISSUE;
                end
                S_ISSUE: state <= S_WAIT;
                S_WAIT: if (rd_done) begin
                    if (last_row) begin
                        state <= S_DRAIN;
                    end else begin
                        state <= S_ISSUE;
                        if (row_cnt == tile_pkg::coord_t'(TILE_ROWS - 1)) begin
                            row_cnt <= '0;
                            map_cnt <= map_cnt + 1'b1;
                        end else begin
                            row_cnt <= row_cnt + 1'b1;
                        end
                    end
                end
                S_DRAIN: if (all_in) state <= S_IDLE;
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            full_q   <= 1'b0;
            word_idx <= '0;
            beat_cnt <= '0;
        end else begin
            if (state == S_IDLE && load_start) beat_cnt <= '0;
            else if (rd_read_buffer)            beat_cnt <= beat_cnt + 1'b1;
            if (push) word_idx <= word_idx + 1'b1; // wraps back to word 0
            if (rd_read_buffer)  full_q <= 1'b1;
            else if (last_word)  full_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_read_buffer) beat_q <= rd_buffer_data;
    end

    // a tile never takes more beats than it holds
    a_no_extra_beat: assert property (@(posedge clk) disable iff (!rst_n)
        rd_read_buffer |-> beat_cnt != BC_W'(TOTAL_BEATS));

endmodule

/* rtl/tile_word_fifo.sv */
// single-clock word FIFO between load and store sides, registered (non-show-ahead) read
`timescale 1ns/1ps

module tile_word_fifo #(
    parameter int FIFO_DEPTH    = 32,
    parameter int FIFO_AF_LEVEL = 28
) (
    input  logic            clk,
    input  logic            rst_n,
    input  logic            push,
    input  tile_pkg::word_t push_data,
    input  logic            pop,
    output tile_pkg::word_t pop_data,
    output logic            empty,
    output logic            almost_full
);

    localparam int AW = $clog2(FIFO_DEPTH);

    tile_pkg::word_t mem [FIFO_DEPTH];
    logic [AW-1:0]   wr_ptr;
    logic [AW-1:0]   rd_ptr;
    logic [AW:0]     count;
    logic            full;

    assign empty       = (count == '0);
    assign full        = (count == (AW+1)'(FIFO_DEPTH));
    assign almost_full = (count >= (AW+1)'(FIFO_AF_LEVEL));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) wr_ptr <= (wr_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (pop)  rd_ptr <= (rd_ptr == AW'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (push) mem[wr_ptr] <= push_data;
        if (pop)  pop_data    <= mem[rd_ptr]; // word shows up a cycle after pop
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n) push |-> !full);
    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n) pop |-> !empty);

endmodule

/* rtl/tile_store_ctrl.sv */
// store side: packs FIFO words into beats and issues one write job per tile row
`timescale 1ns/1ps

module tile_store_ctrl #(
    parameter int FM_ROWS   = 4,
    parameter int FM_COLS   = 16,
    parameter int TILE_MAPS = 2,
    parameter int TILE_ROWS = 4,
    parameter int TILE_COLS = 8
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   store_start,
    input  tile_pkg::tile_origin_t origin,
    input  tile_pkg::addr_t        dst_base,
    output logic                   pop,
    input  tile_pkg::word_t        pop_data,
    input  logic                   empty,
    output logic                   wr_go,
    output tile_pkg::mst_cmd_t     wr_cmd,
    output logic                   wr_write_buffer,
    output tile_pkg::beat_t        wr_write_data,
    input  logic                   wr_buffer_full,
    input  logic                   wr_done,
    output logic                   store_done
);

    localparam int ROW_BEATS = TILE_COLS / tile_pkg::WORDS_PER_BEAT;
    localparam int CW        = $clog2(TILE_COLS + 1);

    typedef enum logic [1:0] {S_IDLE, S_ISSUE, S_FILL, S_WAIT} state_t;

    state_t            state;
    tile_pkg::coord_t  map_cnt;
    tile_pkg::coord_t  row_cnt;
    logic [CW-1:0]     pop_cnt;   // words popped in this row
    logic [CW-1:0]     beat_cnt;  // beats pushed in this row
    tile_pkg::beat_t   pack_q;
    logic [1:0]        word_idx;
    logic              pop_pending;
    logic              beat_full_q;
    logic              room;
    logic              last_row;

    assign last_row = (map_cnt == tile_pkg::coord_t'(TILE_MAPS - 1)) &&
                      (row_cnt == tile_pkg::coord_t'(TILE_ROWS - 1));
    assign room     = !beat_full_q && !(pop_pending && word_idx == 2'd3);

    assign pop = (state == S_FILL) && !empty && room && (pop_cnt != CW'(TILE_COLS));

    assign wr_go           = (state == S_ISSUE);
    assign wr_cmd.base     = tile_pkg::row_addr(dst_base, origin, map_cnt, row_cnt,
                                                FM_ROWS, FM_COLS);
    assign wr_cmd.length   = tile_pkg::addr_t'(TILE_COLS * 4);
    assign wr_write_buffer = beat_full_q && !wr_buffer_full; // hold the beat while full
    assign wr_write_data   = pack_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= S_IDLE;
            map_cnt    <= '0;
            row_cnt    <= '0;
            store_done <= 1'b0;
        end else begin
            store_done <= 1'b0;
            case (state)
                S_IDLE: if (store_start) begin
                    map_cnt <= '0;
                    row_cnt <= '0;
                    state   <= S_ISSUE;
                end
                S_ISSUE: state <= S_FILL;
                S_FILL: if (wr_write_buffer && beat_cnt == CW'(ROW_BEATS - 1)) state <= S_WAIT;
                S_WAIT: if (wr_done) begin
                    if (last_row) begin
                        store_done <= 1'b1;
                        state      <= S_IDLE;
                    end else begin
                        state <= S_ISSUE;
                        if (row_cnt == tile_pkg::coord_t'(TILE_ROWS - 1)) begin
                            row_cnt <= '0;
                            map_cnt <= map_cnt + 1'b1;
                        end else begin
                            row_cnt <= row_cnt + 1'b1;
                        end
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pop_cnt     <= '0;
            beat_cnt    <= '0;
            word_idx    <= '0;
            pop_pending <= 1'b0;
            beat_full_q <= 1'b0;
        end else begin
            pop_pending <= pop;
            if (state == S_ISSUE) begin
                pop_cnt  <= '0;
                beat_cnt <= '0;
            end else begin
                if (pop)             pop_cnt  <= pop_cnt + 1'b1;
                if (wr_write_buffer) beat_cnt <= beat_cnt + 1'b1;
            end
            if (pop_pending) begin
                word_idx <= word_idx + 1'b1;
                if (word_idx == 2'd3) beat_full_q <= 1'b1;
            end else if (wr_write_buffer) begin
                beat_full_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (pop_pending) pack_q[word_idx] <= pop_data;
    end

    // a held beat is never overwritten by a late word
    a_held_beat_kept: assert property (@(posedge clk) disable iff (!rst_n)
        beat_full_q |-> !pop_pending);

endmodule

/* rtl/tile_mover_top.sv */
// tile mover top: load controller feeds the word FIFO, store controller drains it to memory
`timescale 1ns/1ps

module tile_mover_top #(
    parameter int FM_ROWS       = 4,
    parameter int FM_COLS       = 16,
    parameter int TILE_MAPS     = 2,
    parameter int TILE_ROWS     = 4,
    parameter int TILE_COLS     = 8,
    parameter int FIFO_DEPTH    = 32,
    parameter int FIFO_AF_LEVEL = 28
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   load_start,
    output logic                   load_done,
    input  logic                   store_start,
    output logic                   store_done,
    input  tile_pkg::tile_origin_t origin,
    input  tile_pkg::addr_t        src_base,
    input  tile_pkg::addr_t        dst_base,
    output logic                   rd_go,
    output tile_pkg::mst_cmd_t     rd_cmd,
    output logic                   rd_read_buffer,
    input  tile_pkg::beat_t        rd_buffer_data,
    input  logic                   rd_data_available,
    input  logic                   rd_done,
    output logic                   wr_go,
    output tile_pkg::mst_cmd_t     wr_cmd,
    output logic                   wr_write_buffer,
    output tile_pkg::beat_t        wr_write_data,
    input  logic                   wr_buffer_full,
    input  logic                   wr_done
);

    logic            push;
    tile_pkg::word_t push_data;
    logic            almost_full;
    logic            pop;
    tile_pkg::word_t pop_data;
    logic            empty;

    tile_load_ctrl #(
        .FM_ROWS   (FM_ROWS),
        .FM_COLS   (FM_COLS),
        .TILE_MAPS (TILE_MAPS),
        .TILE_ROWS (TILE_ROWS),
        .TILE_COLS (TILE_COLS)
    ) load_ctrl_i (
        .clk               (clk),
        .rst_n             (rst_n),
        .load_start        (load_start),
        .origin            (origin),
        .src_base          (src_base),
        .rd_go             (rd_go),
        .rd_cmd            (rd_cmd),
        .rd_read_buffer    (rd_read_buffer),
        .rd_buffer_data    (rd_buffer_data),
        .rd_data_available (rd_data_available),
        .rd_done           (rd_done),
        .push              (push),
        .push_data         (push_data),
        .almost_full       (almost_full),
        .load_done         (load_done)
    );

    tile_word_fifo #(
        .FIFO_DEPTH    (FIFO_DEPTH),
        .FIFO_AF_LEVEL (FIFO_AF_LEVEL)
    ) fifo_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .push        (push),
        .push_data   (push_data),
        .pop         (pop),
        .pop_data    (pop_data),
        .empty       (empty),
        .almost_full (almost_full)
    );

    tile_store_ctrl #(
        .FM_ROWS   (FM_ROWS),
        .FM_COLS   (FM_COLS),
        .TILE_MAPS (TILE_MAPS),
        .TILE_ROWS (TILE_ROWS),
        .TILE_COLS (TILE_COLS)
    ) store_ctrl_i (
        .clk             (clk),
        .rst_n           (rst_n),
        .store_start     (store_start),
        .origin          (origin),
        .dst_base        (dst_base),
        .pop             (pop),
        .pop_data        (pop_data),
        .empty           (empty),
        .wr_go           (wr_go),
        .wr_cmd          (wr_cmd),
        .wr_write_buffer (wr_write_buffer),
        .wr_write_data   (wr_write_data),
        .wr_buffer_full  (wr_buffer_full),
        .wr_done         (wr_done),
        .store_done      (store_done)
    );

endmodule

/* verification/tile_mem_model.sv */
// testbench memory model serving the tile mover read and write master ports, with random stalls
`timescale 1ns/1ps

module tile_mem_model #(
    parameter int MEM_WORDS = 1024,
    parameter int SEED      = 97
) (
    input  logic                 clk,
    input  logic                 stall_en,
    input  logic                 rd_go,
    input  tile_pkg::mst_cmd_t   rd_cmd,
    input  logic                 rd_read_buffer,
    output tile_pkg::beat_t      rd_buffer_data,
    output logic                 rd_data_available,
    output logic                 rd_done,
    input  logic                 wr_go,
    input  tile_pkg::mst_cmd_t   wr_cmd,
    input  logic                 wr_write_buffer,
    input  tile_pkg::beat_t      wr_write_data,
    output logic                 wr_buffer_full,
    output logic                 wr_done
);

    tile_pkg::word_t mem [MEM_WORDS]; // both feature maps, word addressed
    tile_pkg::beat_t rd_q [$];        // beats fetched but not yet popped
    tile_pkg::addr_t rd_addr = '0;
    tile_pkg::addr_t wr_addr = '0;
    int              rd_left = 0;
    int              wr_left = 0;
    logic            wr_fin  = 1'b0;
    integer          seed    = SEED;

    initial begin
        rd_buffer_data    = '0;
        rd_data_available = 1'b0;
        rd_done           = 1'b0;
        wr_buffer_full    = 1'b0;
        wr_done           = 1'b0;
    end

    always @(posedge clk or negedge clk) begin
        tile_pkg::beat_t b;
        if (clk) begin
            // strobes from the DUT, taken at the edge where it acts on them
            if (rd_read_buffer && rd_q.size() > 0) void'(rd_q.pop_front());
            if (rd_go) begin
                rd_addr = rd_cmd.base;
                rd_left = int'(rd_cmd.length) / 16;
            end
            if (wr_write_buffer) begin
                for (int k = 0; k < tile_pkg::WORDS_PER_BEAT; k++) begin
                    mem[int'(wr_addr >> 2) + k] = wr_write_data[k];
                end
                wr_addr = wr_addr + 32'd16;
                wr_left = wr_left - 1;
                if (wr_left == 0) wr_fin = 1'b1;
            end
            if (wr_go) begin
                wr_addr = wr_cmd.base;
                wr_left = int'(wr_cmd.length) / 16;
            end
        end else begin
            // memory side outputs change on the falling edge
            rd_done = 1'b0;
            if (rd_left > 0 && !(stall_en && (($random(seed) & 3) == 0))) begin
                for (int k = 0; k < tile_pkg::WORDS_PER_BEAT; k++) begin
                    b[k] = mem[int'(rd_addr >> 2) + k];
                end
                rd_q.push_back(b);
                rd_addr = rd_addr + 32'd16;
                rd_left = rd_left - 1;
                if (rd_left == 0) rd_done = 1'b1; // last beat fetched
            end
            rd_data_available = (rd_q.size() > 0) && !(stall_en && (($random(seed) & 3) == 0));
            rd_buffer_data    = (rd_q.size() > 0) ? rd_q[0] : '0;
            wr_done           = wr_fin;
            wr_fin            = 1'b0;
            wr_buffer_full    = stall_en && (($random(seed) & 3) == 0);
        end
    end

endmodule

/* verification/tile_mover_tb.sv */
// testbench for the tile mover: random tiles moved between two feature maps and checked
`timescale 1ns/1ps

module tile_mover_tb;

    localparam int FM_MAPS   = 4;
    localparam int FM_ROWS   = 8;
    localparam int FM_COLS   = 16;
    localparam int TILE_MAPS = 2;
    localparam int TILE_ROWS = 4;
    localparam int TILE_COLS = 8;
    localparam int FM_WORDS  = FM_MAPS * FM_ROWS * FM_COLS;
    localparam int N_JOBS    = TILE_MAPS * TILE_ROWS;
    localparam tile_pkg::addr_t SRC_BASE = 32'd0;
    localparam tile_pkg::addr_t DST_BASE = 32'(FM_WORDS * 4); // second map right after first

    logic                   clk;
    logic                   rst_n;
    logic                   load_start;
    logic                   load_done;
    logic                   store_start;
    logic                   store_done;
    tile_pkg::tile_origin_t origin;
    tile_pkg::addr_t        src_base;
    tile_pkg::addr_t        dst_base;
    logic                   rd_go;
    tile_pkg::mst_cmd_t     rd_cmd;
    logic                   rd_read_buffer;
    tile_pkg::beat_t        rd_buffer_data;
    logic                   rd_data_available;
    logic                   rd_done;
    logic                   wr_go;
    tile_pkg::mst_cmd_t     wr_cmd;
    logic                   wr_write_buffer;
    tile_pkg::beat_t        wr_write_data;
    logic                   wr_buffer_full;
    logic                   wr_done;
    logic                   stall_en;

    integer                 seed;
    int                     errors;
    int                     tests_run;
    int                     tests_failed;
    int                     load_cnt;
    int                     store_cnt;
    int                     strobe_cnt;
    tile_pkg::mst_cmd_t     rd_jobs [$];
    tile_pkg::mst_cmd_t     wr_jobs [$];
    tile_pkg::word_t        ref_dst [FM_WORDS];
    tile_pkg::tile_origin_t last_org;

    tile_mover_top #(
        .FM_ROWS       (FM_ROWS),
        .FM_COLS       (FM_COLS),
        .TILE_MAPS     (TILE_MAPS),
        .TILE_ROWS     (TILE_ROWS),
        .TILE_COLS     (TILE_COLS),
        .FIFO_DEPTH    (32),
        .FIFO_AF_LEVEL (28)
    ) tile_mover_top_i (.*);

    tile_mem_model #(.MEM_WORDS(2 * FM_WORDS), .SEED(97)) mem_i (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        if (rst_n) begin
            if (rd_go) rd_jobs.push_back(rd_cmd);
            if (wr_go) wr_jobs.push_back(wr_cmd);
            if (load_done) load_cnt++;
            if (store_done) store_cnt++;
            if (rd_go || rd_read_buffer || wr_go || wr_write_buffer || load_done || store_done)
                strobe_cnt++;
        end
    end

    task automatic check_val(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            errors++;
            $display("** Error at %0t ns: %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    // byte address of tile row (i, j), worked out from the row layout of a map
    function automatic tile_pkg::addr_t tile_row_addr(input tile_pkg::addr_t base,
            input tile_pkg::tile_origin_t org, input int i, input int j);
        int line;
        line = (int'(org.m) + i) * FM_ROWS + int'(org.row) + j;
        return base + tile_pkg::addr_t'(4 * (line * FM_COLS + int'(org.col)));
    endfunction

    function automatic bit in_tile(input int k, input tile_pkg::tile_origin_t org);
        int m;
        int r;
        int c;
        m = k / (FM_ROWS * FM_COLS);
        r = (k / FM_COLS) % FM_ROWS;
        c = k % FM_COLS;
        return m >= int'(org.m) && m < int'(org.m) + TILE_MAPS
            && r >= int'(org.row) && r < int'(org.row) + TILE_ROWS
            && c >= int'(org.col) && c < int'(org.col) + TILE_COLS;
    endfunction

    task automatic wait_tile(input int target);
        int cyc;
        cyc = 0;
        while ((load_cnt < target || store_cnt < target) && cyc < 5000) begin
            @(negedge clk);
            cyc++;
        end
        if (cyc >= 5000) begin
            errors++;
            $display("timeout: tile never finished, %0d load_done and %0d store_done seen",
                     load_cnt, store_cnt);
        end
    endtask

    task automatic run_tile(input int gap);
        tile_pkg::tile_origin_t org;
        int target;
        int src_w;
        int dst_w;
        org.m   = tile_pkg::coord_t'($unsigned($random(seed)) % (FM_MAPS - TILE_MAPS + 1));
        org.row = tile_pkg::coord_t'($unsigned($random(seed)) % (FM_ROWS - TILE_ROWS + 1));
        org.col = tile_pkg::coord_t'(
            4 * ($unsigned($random(seed)) % ((FM_COLS - TILE_COLS) / 4 + 1)));
        last_org = org;
        target = load_cnt + 1;
        rd_jobs.delete();
        wr_jobs.delete();
        @(negedge clk);
        origin     = org;
        load_start = 1'b1;
        @(negedge clk);
        load_start = 1'b0;
        repeat (gap) @(negedge clk);
        store_start = 1'b1;
        @(negedge clk);
        store_start = 1'b0;
        wait_tile(target);
        repeat (6) @(negedge clk); // stray extra done pulses would land here
        check_val("load_done count", 64'(target), 64'(load_cnt));
        check_val("store_done count", 64'(target), 64'(store_cnt));
        for (int i = 0; i < TILE_MAPS; i++) begin
            for (int j = 0; j < TILE_ROWS; j++) begin
                src_w = int'(tile_row_addr(SRC_BASE, org, i, j) >> 2);
                dst_w = int'((tile_row_addr(DST_BASE, org, i, j) - DST_BASE) >> 2);
                for (int k = 0; k < TILE_COLS; k++) ref_dst[dst_w + k] = mem_i.mem[src_w + k];
            end
        end
        for (int k = 0; k < FM_WORDS; k++)
            check_val($sformatf("dst[%0d]", k), 64'(ref_dst[k]), 64'(mem_i.mem[FM_WORDS + k]));
        check_val("rd job count", 64'(N_JOBS), 64'(rd_jobs.size()));
        check_val("wr job count", 64'(N_JOBS), 64'(wr_jobs.size()));
        for (int n = 0; n < N_JOBS; n++) begin
            if (n < rd_jobs.size())
                check_val($sformatf("rd_cmd[%0d]", n),
                          {tile_row_addr(SRC_BASE, org, n / TILE_ROWS, n % TILE_ROWS),
                           32'(TILE_COLS * 4)},
                          rd_jobs[n]);
            if (n < wr_jobs.size())
                check_val($sformatf("wr_cmd[%0d]", n),
                          {tile_row_addr(DST_BASE, org, n / TILE_ROWS, n % TILE_ROWS),
                           32'(TILE_COLS * 4)},
                          wr_jobs[n]);
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (errors != errs_before) tests_failed++;
        $display("test %0d %s: %s", tests_run, name, (errors == errs_before) ? "ok" : "FAILED");
    endtask

    initial begin
        int e;
        seed         = 97;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        load_cnt     = 0;
        store_cnt    = 0;
        strobe_cnt   = 0;
        rst_n        = 1'b0;
        load_start   = 1'b0;
        store_start  = 1'b0;
        origin       = '0;
        src_base     = SRC_BASE;
        dst_base     = DST_BASE;
        stall_en     = 1'b0;
        for (int k = 0; k < FM_WORDS; k++) begin
            mem_i.mem[k]            = $random(seed);
            mem_i.mem[FM_WORDS + k] = 32'hd500_0000 | k; // pattern follows the word address
            ref_dst[k]              = 32'hd500_0000 | k;
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        e = errors;
        strobe_cnt = 0;
        repeat (10) @(negedge clk);
        check_val("strobes after reset", 64'd0, 64'(strobe_cnt));
        report_test("idle after reset", e);

        e = errors;
        run_tile(40); // store only after the load has run well ahead
        report_test("single tile copy", e);

        e = errors;
        for (int k = 0; k < FM_WORDS; k++) begin
            if (!in_tile(k, last_org))
                check_val($sformatf("outside dst[%0d]", k), 64'(32'hd500_0000 | k),
                          64'(mem_i.mem[FM_WORDS + k]));
        end
        report_test("words outside tile untouched", e);

        e = errors;
        stall_en = 1'b1;
        run_tile(2);
        report_test("stalls and job order", e);

        e = errors;
        repeat (5) run_tile(1);
        stall_en = 1'b0;
        report_test("five back-to-back tiles", e);

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (tests_failed == 0 && errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

/* src.f */
rtl/tile_pkg.sv
rtl/tile_load_ctrl.sv
rtl/tile_word_fifo.sv
rtl/tile_store_ctrl.sv
rtl/tile_mover_top.sv
verification/tile_mem_model.sv
verification/tile_mover_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the tile mover testbench with Verilator, run it, and search for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f src.f --top-module tile_mover_tb -o tile_mover_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

out=$(./obj_dir/tile_mover_sim)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "All tests passed"; then
    exit 0
fi
exit 1
